//--- rv_alu.sv
`include "rv_defines.svh"
`default_nettype none

module rv_alu (
    input  rv_pkg::rv_alu_op_e  op_i,
    input  logic [`RV_XLEN-1:0] a_i,
    input  logic [`RV_XLEN-1:0] b_i,
    output logic [`RV_XLEN-1:0] result_o
);

logic [4:0] shamt;
logic       lt;
logic       ltu;

// only the low bits count for shifts
assign shamt = b_i[4:0];
assign lt = $signed(a_i) < $signed(b_i);
assign ltu = a_i < b_i;

always_comb begin
    case (op_i)
        rv_pkg::ALU_ADD:    result_o = a_i + b_i;
        rv_pkg::ALU_SUB:    result_o = a_i - b_i;
        rv_pkg::ALU_AND:    result_o = a_i & b_i;
        rv_pkg::ALU_OR:     result_o = a_i | b_i;
        rv_pkg::ALU_XOR:    result_o = a_i ^ b_i;
        rv_pkg::ALU_SLL:    result_o = a_i << shamt;
        rv_pkg::ALU_SRL:    result_o = a_i >> shamt;
        rv_pkg::ALU_SRA:    result_o = $signed(a_i) >>> shamt;
        rv_pkg::ALU_SLT:    result_o = `RV_XLEN'(lt);
        rv_pkg::ALU_SLTU:   result_o = `RV_XLEN'(ltu);
        // lui immediate goes through untouched
        rv_pkg::ALU_PASS_B: result_o = b_i;
        default:            result_o = '0;
    endcase
end

endmodule

`default_nettype wire

//--- rv_branch_unit.sv
`include "rv_defines.svh"
`default_nettype none

module rv_branch_unit (
    input  rv_pkg::rv_ctrl_t     ctrl_i,
    input  logic [`RV_XLEN-1:0]  pc_i,
    input  logic [`RV_XLEN-1:0]  rs1_i,
    input  logic [`RV_XLEN-1:0]  rs2_i,
    output rv_pkg::rv_redirect_t redirect_o
);

logic eq, lt, ltu;
logic taken;

assign eq = (rs1_i == rs2_i);
assign lt = ($signed(rs1_i) < $signed(rs2_i));
assign ltu = (rs1_i < rs2_i);

always_comb begin
    case (ctrl_i.br_op)
        rv_pkg::BR_EQ:  taken = eq;
        rv_pkg::BR_NE:  taken = !eq;
        rv_pkg::BR_LT:  taken = lt;
        rv_pkg::BR_GE:  taken = !lt;
        rv_pkg::BR_LTU: taken = ltu;
        rv_pkg::BR_GEU: taken = !ltu;
        default:        taken = 1'b0;
    endcase
end

// jal and branches share the pc relative target
assign redirect_o.valid = ctrl_i.is_jal || (ctrl_i.is_branch && taken);
assign redirect_o.target = pc_i + ctrl_i.imm;

endmodule

`default_nettype wire

//--- rv_core.f
rv_pkg.sv
rv_fetch.sv
rv_decoder.sv
rv_reg_file.sv
rv_alu.sv
rv_branch_unit.sv
rv_execute.sv
rv_core.sv
tb_clk_gen.sv
tb_rv_core.sv
+incdir+.

//--- rv_core.sv
`include "rv_defines.svh"
`default_nettype none

module rv_core (
    input  logic                   clk,
    input  logic                   rst,
    output logic [`RV_IMEM_AW-1:0] imem_addr_o,
    input  logic [`RV_XLEN-1:0]    imem_data_i,
    output rv_pkg::rv_retire_t     retire_o
);

rv_pkg::rv_inst_u     inst;
logic [`RV_XLEN-1:0]  pc;
logic                 valid;
rv_pkg::rv_ctrl_t     ctrl;
logic [`RV_XLEN-1:0]  rs1_data, rs2_data;
rv_pkg::rv_redirect_t redirect;

// --------------------
// fetch

rv_fetch rv_fetch_i (
    .clk         (clk),
    .rst         (rst),
    .redirect_i  (redirect),
    .imem_addr_o (imem_addr_o),
    .imem_data_i (imem_data_i),
    .inst_o      (inst),
    .pc_o        (pc),
    .valid_o     (valid)
);

// --------------------
// decode and register read

rv_decoder rv_decoder_i (
    .inst_i  (inst),
    .valid_i (valid),
    .ctrl_o  (ctrl)
);

rv_reg_file rv_reg_file_i (
    .clk        (clk),
    .rst        (rst),
    .rs1_i      (inst.r_fmt.rs1),
    .rs2_i      (inst.r_fmt.rs2),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .retire_i   (retire_o)
);

// --------------------
// execute

rv_execute rv_execute_i (
    .clk        (clk),
    .rst        (rst),
    .ctrl_i     (ctrl),
    .pc_i       (pc),
    .valid_i    (valid),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .redirect_o (redirect),
    .retire_o   (retire_o)
);

endmodule

`default_nettype wire

//--- rv_decoder.sv
`include "rv_defines.svh"
`default_nettype none

module rv_decoder (
    input  rv_pkg::rv_inst_u inst_i,
    input  logic             valid_i,
    output rv_pkg::rv_ctrl_t ctrl_o
);

logic [2:0]          funct3;
logic                alt;
rv_pkg::rv_alu_op_e  arith_op;
logic [`RV_XLEN-1:0] imm_i, imm_b, imm_u, imm_j;

assign funct3 = inst_i.r_fmt.funct3;

// bit 30 picks sub and sra but addi has no sub form
assign alt = inst_i.r_fmt.funct7[5] &&
    ((inst_i.r_fmt.opcode == rv_pkg::OPC_OP) || (funct3 == 3'b101));

always_comb begin
    case (funct3)
        3'b000: arith_op = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
        3'b001: arith_op = rv_pkg::ALU_SLL;
        3'b010: arith_op = rv_pkg::ALU_SLT;
        3'b011: arith_op = rv_pkg::ALU_SLTU;
        3'b100: arith_op = rv_pkg::ALU_XOR;
        3'b101: arith_op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
        3'b110: arith_op = rv_pkg::ALU_OR;
        default: arith_op = rv_pkg::ALU_AND;
    endcase
end

// --------------------
// immediates per format

assign imm_i = {{20{inst_i.i_fmt.imm[11]}}, inst_i.i_fmt.imm};
assign imm_b = {{20{inst_i.b_fmt.imm_12}}, inst_i.b_fmt.imm_11,
    inst_i.b_fmt.imm_10_5, inst_i.b_fmt.imm_4_1, 1'b0};
assign imm_u = {inst_i.u_fmt.imm_31_12, 12'h000};
assign imm_j = {{12{inst_i.j_fmt.imm_20}}, inst_i.j_fmt.imm_19_12,
    inst_i.j_fmt.imm_11, inst_i.j_fmt.imm_10_1, 1'b0};

// --------------------
// control

always_comb begin
    ctrl_o = '0;
    ctrl_o.br_op = rv_pkg::rv_br_op_e'(funct3);
    ctrl_o.rs1 = inst_i.r_fmt.rs1;
    ctrl_o.rs2 = inst_i.r_fmt.rs2;
    case (inst_i.r_fmt.opcode)
        rv_pkg::OPC_OP: begin
            ctrl_o.alu_op = arith_op;
            ctrl_o.rd_we = 1'b1;
            ctrl_o.rd = inst_i.r_fmt.rd;
        end
        rv_pkg::OPC_OP_IMM: begin
            ctrl_o.alu_op = arith_op;
            ctrl_o.b_sel = rv_pkg::B_SEL_IMM;
            ctrl_o.imm = imm_i;
            ctrl_o.rd_we = 1'b1;
            ctrl_o.rd = inst_i.i_fmt.rd;
        end
        rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC: begin
            // lui passes the immediate and auipc adds it to pc
            ctrl_o.alu_op = inst_i.u_fmt.opcode[5] ? rv_pkg::ALU_PASS_B : rv_pkg::ALU_ADD;
            ctrl_o.a_sel = rv_pkg::A_SEL_PC;
            ctrl_o.b_sel = rv_pkg::B_SEL_IMM;
            ctrl_o.imm = imm_u;
            ctrl_o.rd_we = 1'b1;
            ctrl_o.rd = inst_i.u_fmt.rd;
        end
        rv_pkg::OPC_BRANCH: begin
            ctrl_o.is_branch = 1'b1;
            ctrl_o.imm = imm_b;
        end
        rv_pkg::OPC_JAL: begin
            ctrl_o.is_jal = 1'b1;
            ctrl_o.wb_sel = rv_pkg::WB_SEL_PC4;
            ctrl_o.imm = imm_j;
            ctrl_o.rd_we = 1'b1;
            ctrl_o.rd = inst_i.j_fmt.rd;
        end
        default: ;
    endcase
    // bubbles carry no side effects
    if (!valid_i) begin
        ctrl_o.rd_we = 1'b0;
        ctrl_o.is_branch = 1'b0;
        ctrl_o.is_jal = 1'b0;
    end
end

endmodule

`default_nettype wire

//--- rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// --------------------
// datapath

// integer register and data width
`define RV_XLEN 32

// register file addressing
`define RV_REG_AW 5
`define RV_NUM_REGS 32

// --------------------
// fetch

// word address into instruction memory
`define RV_IMEM_AW 10

// first pc after reset
`define RV_RESET_VECTOR 32'h0000_0000

`endif

//--- rv_execute.sv
`include "rv_defines.svh"
`default_nettype none

module rv_execute (
    input  logic                 clk,
    input  logic                 rst,
    input  rv_pkg::rv_ctrl_t     ctrl_i,
    input  logic [`RV_XLEN-1:0]  pc_i,
    input  logic                 valid_i,
    input  logic [`RV_XLEN-1:0]  rs1_data_i,
    input  logic [`RV_XLEN-1:0]  rs2_data_i,
    output rv_pkg::rv_redirect_t redirect_o,
    output rv_pkg::rv_retire_t   retire_o
);

// --------------------
// writeback forwarding

logic                wb_hit;
logic                fwd_rs1, fwd_rs2;
logic [`RV_XLEN-1:0] rs1_val, rs2_val;

// the retire register is written into the file only at the end of this cycle
assign wb_hit = retire_o.valid && retire_o.we && (retire_o.rd != '0);
assign fwd_rs1 = wb_hit && (retire_o.rd == ctrl_i.rs1);
assign fwd_rs2 = wb_hit && (retire_o.rd == ctrl_i.rs2);

assign rs1_val = fwd_rs1 ? retire_o.data : rs1_data_i;
assign rs2_val = fwd_rs2 ? retire_o.data : rs2_data_i;

// --------------------
// operands and units

logic [`RV_XLEN-1:0]  op_a, op_b;
logic [`RV_XLEN-1:0]  alu_out;
logic [`RV_XLEN-1:0]  result;
rv_pkg::rv_redirect_t br_redirect;

assign op_a = (ctrl_i.a_sel == rv_pkg::A_SEL_PC) ? pc_i : rs1_val;
assign op_b = (ctrl_i.b_sel == rv_pkg::B_SEL_IMM) ? ctrl_i.imm : rs2_val;

rv_alu rv_alu_i (
    .op_i     (ctrl_i.alu_op),
    .a_i      (op_a),
    .b_i      (op_b),
    .result_o (alu_out)
);

// branch compares the forwarded registers and not the selected operands
rv_branch_unit rv_branch_unit_i (
    .ctrl_i     (ctrl_i),
    .pc_i       (pc_i),
    .rs1_i      (rs1_val),
    .rs2_i      (rs2_val),
    .redirect_o (br_redirect)
);

assign result = (ctrl_i.wb_sel == rv_pkg::WB_SEL_PC4) ? (pc_i + `RV_XLEN'(4)) : alu_out;

assign redirect_o.valid = br_redirect.valid && valid_i;
assign redirect_o.target = br_redirect.target;

// --------------------
// execute to writeback register

always_ff @(posedge clk) begin
    retire_o.pc   <= pc_i;
    retire_o.rd   <= ctrl_i.rd;
    retire_o.we   <= ctrl_i.rd_we;
    retire_o.data <= result;
    if (rst) begin
        retire_o.valid <= 1'b0;
    end else begin
        retire_o.valid <= valid_i;
    end
end

endmodule

`default_nettype wire

//--- rv_fetch.sv
`include "rv_defines.svh"
`default_nettype none

module rv_fetch (
    input  logic                   clk,
    input  logic                   rst,
    input  rv_pkg::rv_redirect_t   redirect_i,
    output logic [`RV_IMEM_AW-1:0] imem_addr_o,
    input  logic [`RV_XLEN-1:0]    imem_data_i,
    output rv_pkg::rv_inst_u       inst_o,
    output logic [`RV_XLEN-1:0]    pc_o,
    output logic                   valid_o
);

// --------------------
// program counter

logic [`RV_XLEN-1:0] pc_q;

always_ff @(posedge clk) begin
    if (rst) begin
        pc_q <= `RV_RESET_VECTOR;
    end else if (redirect_i.valid) begin
        pc_q <= redirect_i.target;
    end else begin
        pc_q <= pc_q + `RV_XLEN'(4);
    end
end

// memory is word addressed so the byte offset is dropped
assign imem_addr_o = pc_q[`RV_IMEM_AW+1:2];

// --------------------
// fetch to execute register

always_ff @(posedge clk) begin
    inst_o <= imem_data_i;
    pc_o   <= pc_q;
    // word fetched while a jump resolves is off the taken path
    if (rst || redirect_i.valid) begin
        valid_o <= 1'b0;
    end else begin
        valid_o <= 1'b1;
    end
end

endmodule

`default_nettype wire

//--- rv_pkg.sv
`include "rv_defines.svh"
`default_nettype none

package rv_pkg;

// --------------------
// encodings

typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
} rv_opcode_e;

typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
    ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_PASS_B
} rv_alu_op_e;

// same values as funct3 of the branch group
typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
} rv_br_op_e;

typedef enum logic {A_SEL_REG, A_SEL_PC} rv_a_sel_e;
typedef enum logic {B_SEL_REG, B_SEL_IMM} rv_b_sel_e;
typedef enum logic {WB_SEL_ALU, WB_SEL_PC4} rv_wb_sel_e;

// --------------------
// instruction formats

typedef struct packed {
    logic [6:0]            funct7;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [`RV_REG_AW-1:0] rd;
    logic [6:0]            opcode;
} rv_r_fmt_t;

typedef struct packed {
    logic [11:0]           imm;
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [`RV_REG_AW-1:0] rd;
    logic [6:0]            opcode;
} rv_i_fmt_t;

typedef struct packed {
    logic                  imm_12;
    logic [5:0]            imm_10_5;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [3:0]            imm_4_1;
    logic                  imm_11;
    logic [6:0]            opcode;
} rv_b_fmt_t;

typedef struct packed {
    logic [19:0]           imm_31_12;
    logic [`RV_REG_AW-1:0] rd;
    logic [6:0]            opcode;
} rv_u_fmt_t;

typedef struct packed {
    logic                  imm_20;
    logic [9:0]            imm_10_1;
    logic                  imm_11;
    logic [7:0]            imm_19_12;
    logic [`RV_REG_AW-1:0] rd;
    logic [6:0]            opcode;
} rv_j_fmt_t;

// one word read through whichever format the opcode calls for
typedef union packed {
    rv_r_fmt_t r_fmt;
    rv_i_fmt_t i_fmt;
    rv_b_fmt_t b_fmt;
    rv_u_fmt_t u_fmt;
    rv_j_fmt_t j_fmt;
} rv_inst_u;

// --------------------
// pipeline records

typedef struct packed {
    rv_alu_op_e            alu_op;
    rv_a_sel_e             a_sel;
    rv_b_sel_e             b_sel;
    rv_wb_sel_e            wb_sel;
    logic                  rd_we;
    logic                  is_branch;
    logic                  is_jal;
    rv_br_op_e             br_op;
    logic [`RV_REG_AW-1:0] rs1;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_XLEN-1:0]   imm;
} rv_ctrl_t;

typedef struct packed {
    logic                valid;
    logic [`RV_XLEN-1:0] target;
} rv_redirect_t;

typedef struct packed {
    logic                  valid;
    logic [`RV_XLEN-1:0]   pc;
    logic [`RV_REG_AW-1:0] rd;
    logic                  we;
    logic [`RV_XLEN-1:0]   data;
} rv_retire_t;

endpackage

`default_nettype wire

//--- rv_reg_file.sv
`include "rv_defines.svh"
`default_nettype none

module rv_reg_file (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`RV_REG_AW-1:0] rs1_i,
    input  logic [`RV_REG_AW-1:0] rs2_i,
    output logic [`RV_XLEN-1:0]   rs1_data_o,
    output logic [`RV_XLEN-1:0]   rs2_data_o,
    input  rv_pkg::rv_retire_t    retire_i
);

// x0 has no storage
logic [`RV_XLEN-1:0] regs [1:`RV_NUM_REGS-1];

// architectural state starts at zero
always_ff @(posedge clk) begin
    if (rst) begin
        for (int i = 1; i < `RV_NUM_REGS; i++) begin
            regs[i] <= '0;
        end
    end else if (retire_i.valid && retire_i.we && (retire_i.rd != '0)) begin
        regs[retire_i.rd] <= retire_i.data;
    end
end

// --------------------
// read ports

assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
`default_nettype none

module tb_clk_gen (
    input  logic restart_i,
    output logic clk_o,
    output logic rst_o
);

timeunit 1ns;
timeprecision 1ps;

// reset cycles still to go
logic [1:0] rst_cnt = 2'd2;

initial clk_o = 1'b0;
always #20 clk_o = ~clk_o;

always @(posedge clk_o) begin
    if (restart_i) begin
        rst_cnt <= 2'd2;
    end else if (rst_cnt != 2'd0) begin
        rst_cnt <= rst_cnt - 2'd1;
    end
end

assign rst_o = (rst_cnt != 2'd0);

endmodule

`default_nettype wire

//--- tb_rv_core.sv
`include "rv_defines.svh"
`default_nettype none

module tb_rv_core;

timeunit 1ns;
timeprecision 1ps;

localparam int NTESTS = 4;

logic                   clk, rst, restart;
logic [`RV_IMEM_AW-1:0] imem_addr;
logic [`RV_XLEN-1:0]    imem_data_i;
rv_pkg::rv_retire_t     retire;

tb_clk_gen clk_gen0 (.restart_i(restart), .clk_o(clk), .rst_o(rst));

rv_core dut0 (
    .clk         (clk),
    .rst         (rst),
    .imem_addr_o (imem_addr),
    .imem_data_i (imem_data_i),
    .retire_o    (retire)
);

logic [31:0] progs [NTESTS][1024];
int          plen [NTESTS];
string       names [NTESTS] = '{"alu", "forward", "branch", "jal"};
logic [31:0] seed = 32'hbc06_30f4;
int          cur_t, limit, cyc, since_rst, last_cyc, nret, errors, test_errs, failed;
logic        active, done, prev_taken;
logic [31:0] mregs [32];
logic [31:0] mpc;

// --------------------
// stimulus helpers

function automatic logic [31:0] xorshift();
    seed = seed ^ (seed << 13);
    seed = seed ^ (seed >> 17);
    seed = seed ^ (seed << 5);
    return seed;
endfunction

function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                      logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
    rv_pkg::rv_inst_u u;
    u = '0;
    u.r_fmt.funct7 = f7;
    u.r_fmt.rs2 = rs2;
    u.r_fmt.rs1 = rs1;
    u.r_fmt.funct3 = f3;
    u.r_fmt.rd = rd;
    u.r_fmt.opcode = opc;
    return u;
endfunction

function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                      logic [4:0] rd);
    rv_pkg::rv_inst_u u;
    u = '0;
    u.i_fmt.imm = imm;
    u.i_fmt.rs1 = rs1;
    u.i_fmt.funct3 = f3;
    u.i_fmt.rd = rd;
    u.i_fmt.opcode = 7'b0010011;
    return u;
endfunction

function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
    rv_pkg::rv_inst_u u;
    u = '0;
    u.u_fmt.imm_31_12 = imm;
    u.u_fmt.rd = rd;
    u.u_fmt.opcode = opc;
    return u;
endfunction

function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                      logic [2:0] f3);
    rv_pkg::rv_inst_u u;
    u = '0;
    u.b_fmt.imm_12 = imm[12];
    u.b_fmt.imm_11 = imm[11];
    u.b_fmt.imm_10_5 = imm[10:5];
    u.b_fmt.imm_4_1 = imm[4:1];
    u.b_fmt.rs2 = rs2;
    u.b_fmt.rs1 = rs1;
    u.b_fmt.funct3 = f3;
    u.b_fmt.opcode = 7'b1100011;
    return u;
endfunction

function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    rv_pkg::rv_inst_u u;
    u = '0;
    u.j_fmt.imm_20 = imm[20];
    u.j_fmt.imm_19_12 = imm[19:12];
    u.j_fmt.imm_11 = imm[11];
    u.j_fmt.imm_10_1 = imm[10:1];
    u.j_fmt.rd = rd;
    u.j_fmt.opcode = 7'b1101111;
    return u;
endfunction

task automatic emit(input logic [31:0] w);
    progs[cur_t][plen[cur_t]] = w;
    plen[cur_t]++;
endtask

// lui plus addi with the upper part rounded for the signed low half
task automatic emit_li(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] hi;
    hi = (v + 32'h800) >> 12;
    emit(enc_u(hi[19:0], rd, 7'b0110111));
    emit(enc_i(v[11:0], rd, 3'b000, rd));
endtask

task automatic emit_alu(input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2,
                        input bit allow_u);
    logic [2:0]  f3;
    logic [31:0] r;
    logic [11:0] imm;
    f3 = xorshift() % 8;
    r = xorshift();
    imm = r[11:0];
    if (f3 == 3'b001 || f3 == 3'b101) begin
        imm = {1'b0, r[5] && (f3 == 3'b101), 5'b0, r[4:0]};
    end
    case (allow_u ? r[31:30] : {1'b0, r[30]})
        2'd0: emit(enc_r({1'b0, r[6] && (f3 == 3'b000 || f3 == 3'b101), 5'b0},
                         rs2, rs1, f3, rd, 7'b0110011));
        2'd1: emit(enc_i(imm, rs1, f3, rd));
        2'd2: emit(enc_u(r[27:8], rd, 7'b0110111));
        default: emit(enc_u(r[27:8], rd, 7'b0010111));
    endcase
endtask

task automatic build_programs();
    logic [31:0] a, b;
    logic [4:0]  x, y;
    logic [2:0]  f3s [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    int          k;
    cur_t = 0;
    for (int i = 1; i < 9; i++) emit_li(xorshift() % 31 + 1, xorshift());
    // x0 written then read at distance 1 and 2
    emit(enc_u(20'hfffff, 5'd0, 7'b0110111));
    emit(enc_r(7'd0, 5'd0, 5'd0, 3'b110, 5'd6, 7'b0110011));
    emit(enc_r(7'd0, 5'd0, 5'd0, 3'b110, 5'd7, 7'b0110011));
    for (int i = 0; i < 40; i++) emit_alu(xorshift() % 32, xorshift() % 32, xorshift() % 32, 1);
    emit(enc_j(21'd0, 5'd0));
    cur_t = 1;
    for (int i = 1; i < 6; i++) emit_li(i, xorshift());
    // producer then readers at distance 1 and 2
    for (int i = 0; i < 12; i++) begin
        x = xorshift() % 31 + 1;
        y = xorshift() % 31 + 1;
        emit_alu(x, xorshift() % 32, xorshift() % 32, 1);
        emit_alu(y, x, xorshift() % 32, 0);
        emit_alu(xorshift() % 32, y, x, 0);
    end
    emit(enc_j(21'd0, 5'd0));
    cur_t = 2;
    for (int i = 0; i < 12; i++) begin
        a = xorshift();
        b = xorshift();
        if (f3s[i / 2][2] == 1'b0) begin
            if ((f3s[i / 2][0] == 1'b0) == (i % 2 == 0)) b = a;
            else if (a == b) b = a + 1;
        end else if (br_ref(f3s[i / 2], a, b) != (i % 2 == 0)) begin
            {a, b} = {b, a};
        end
        emit_li(5'd1, a);
        emit_li(5'd2, b);
        emit(enc_b(13'd8, 5'd2, 5'd1, f3s[i / 2]));
        emit(enc_i(12'd1, 5'd3, 3'b000, 5'd3));
        emit(enc_i(12'd1, 5'd4, 3'b000, 5'd4));
    end
    emit(enc_j(21'd0, 5'd0));
    cur_t = 3;
    for (int i = 0; i < 8; i++) begin
        x = xorshift() % 32;
        k = xorshift() % 2 + 1;
        emit(enc_j(21'(4 * (k + 1)), x));
        for (int j = 0; j < k; j++) emit(enc_i(12'd1, 5'd5, 3'b000, 5'd5));
        emit_alu(xorshift() % 31 + 1, x, x, 0);
    end
    emit(enc_j(21'd0, 5'd0));
endtask

// --------------------
// reference model

function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] a,
                                        logic [31:0] b);
    case (f3)
        3'b000: return alt ? a - b : a + b;
        3'b001: return a << b[4:0];
        3'b010: return {31'b0, $signed(a) < $signed(b)};
        3'b011: return {31'b0, a < b};
        3'b100: return a ^ b;
        3'b101: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'b110: return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic br_ref(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
    case (f3)
        3'b000: return a == b;
        3'b001: return a != b;
        3'b100: return $signed(a) < $signed(b);
        3'b101: return $signed(a) >= $signed(b);
        3'b110: return a < b;
        3'b111: return a >= b;
        default: return 1'b0;
    endcase
endfunction

task automatic report_mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
    $display("[ERROR] %s: %s expected %h actual %h", names[cur_t], what, exp, act);
    errors++;
    test_errs++;
endtask

task automatic check_retire();
    logic [31:0] w, a, b, data, nxt;
    logic [4:0]  rd;
    logic        we;
    w = progs[cur_t][mpc[11:2]];
    rd = w[11:7];
    a = mregs[w[19:15]];
    b = mregs[w[24:20]];
    we = 1'b1;
    data = '0;
    nxt = mpc + 4;
    case (w[6:0])
        7'b0110011: data = alu_ref(w[14:12], w[30], a, b);
        7'b0010011: data = alu_ref(w[14:12], w[30] && w[14:12] == 3'b101, a,
                                   {{20{w[31]}}, w[31:20]});
        7'b0110111: data = {w[31:12], 12'h0};
        7'b0010111: data = mpc + {w[31:12], 12'h0};
        7'b1100011: begin
            we = 1'b0;
            if (br_ref(w[14:12], a, b)) nxt = mpc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        end
        7'b1101111: begin
            data = mpc + 4;
            nxt = mpc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        end
        default: we = 1'b0;
    endcase
    assert (retire.pc == mpc) else report_mismatch("pc", mpc, retire.pc);
    assert (retire.we == we) else report_mismatch("we", we, retire.we);
    if (we) begin
        assert (retire.rd == rd) else report_mismatch("rd", rd, retire.rd);
        assert (retire.data == data) else report_mismatch("data", data, retire.data);
    end
    if (nret == 0) begin
        assert (since_rst == 3) else report_mismatch("first retire cycle", 3, since_rst);
    end else begin
        assert (cyc - last_cyc == (prev_taken ? 2 : 1))
            else report_mismatch("retire spacing", prev_taken ? 2 : 1, cyc - last_cyc);
    end
    if (we && rd != 5'd0) mregs[rd] = data;
    done = (nxt == mpc);
    prev_taken = (nxt != mpc + 4);
    last_cyc = cyc;
    nret++;
    mpc = nxt;
endtask

// --------------------
// memory, checker, watchdog

always @(negedge clk) begin
    imem_data_i <= progs[cur_t][imem_addr];
end

always @(negedge clk) begin
    cyc++;
    if (limit > 0 && cyc > limit) begin
        $display("run timed out after %0d cycles", cyc);
        $display("Something failed");
        $finish;
    end else begin
        since_rst = rst ? 0 : since_rst + 1;
        if (active && !rst && !done && retire.valid) check_retire();
    end
end

task automatic run_test(input int t);
    @(negedge clk);
    active = 1'b0;
    restart = 1'b1;
    cur_t = t;
    foreach (mregs[i]) mregs[i] = '0;
    mpc = `RV_RESET_VECTOR;
    done = 1'b0;
    nret = 0;
    test_errs = 0;
    @(negedge clk);
    restart = 1'b0;
    active = 1'b1;
    while (!done) @(negedge clk);
    $display("test %s: %0d retired, %0d errors", names[t], nret, test_errs);
    if (test_errs != 0) failed++;
endtask

initial begin
    int total;
    imem_data_i = '0;
    restart = 1'b0;
    active = 1'b0;
    done = 1'b0;
    cur_t = 0;
    total = 0;
    foreach (progs[t, i]) progs[t][i] = '0;
    foreach (plen[t]) plen[t] = 0;
    build_programs();
    foreach (plen[t]) total += plen[t];
    limit = 2 * total + 20 * NTESTS;
    for (int t = 0; t < NTESTS; t++) run_test(t);
    $display("tests %0d, failed %0d, errors %0d", NTESTS, failed, errors);
    if (errors == 0) begin
        $display("Everything OK");
    end else begin
        $display("Something failed");
    end
    $finish;
end

endmodule

`default_nettype wire
